// File: files.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/register_free_list.sv
verilog/id_tracker.sv
verilog/issue_stage.sv
verilog/renamer.sv
verilog/rename_unit.sv
testbench/rename_checker.sv
testbench/rename_tb.sv

// File: testbench/rename_checker.sv
// Reference model of the rename map, free list and in-flight window; compares DUT outputs each cycle
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_checker
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  decode_req_t     decode,
    input  rename_resp_t    rename,
    input  logic            stall,
    input  logic            flush,
    input  logic            retire_strobe,
    input  logic            init_done,
    input  logic [8*16-1:0] test_name,
    output int              errors,
    output int              checks
);

    // Reference state
    phys_addr_t map [`ARCH_REGS];
    int         free_q [$];
    // Old mapping per in-flight instruction, 0 if it frees nothing
    int         old_q [$];
    int         alloc_count;
    int         init_cycles;
    int         err_count = 0;
    int         check_count = 0;
    logic       ready;
    // Instruction renamed last cycle, the one a flush undoes
    logic       last_valid;
    logic       last_has_rd;
    arch_addr_t last_rd;
    phys_addr_t last_old;
    phys_addr_t last_new;

    assign errors = err_count;
    assign checks = check_count;

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("error %0s: %0s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic flag(input string msg);
        err_count++;
        $display("error %0s: %0s", test_name, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One cycle of the model

    task automatic check_and_update();
        logic exp_stall;
        logic accept;
        logic takes_rd;
        int   old;
        exp_stall = (free_q.size() == 0) || (old_q.size() == `MAX_IDS);
        compare("stall", exp_stall, stall);
        compare("init_done", 1, init_done);
        // Entry 0 holds physical 0, so x0 needs no special case
        for (int i = 0; i < `READ_PORTS; i++) begin
            compare("phys_rs_addr", map[decode.rs_addr[i]], rename.phys_rs_addr[i]);
        end
        accept   = decode.valid && !exp_stall && !flush;
        takes_rd = accept && decode.uses_rd && (decode.rd_addr != 0);
        compare("phys_rd_addr", takes_rd ? free_q[0] : 0, rename.phys_rd_addr);
        if (decode.valid) begin
            compare("id", alloc_count % `MAX_IDS, rename.id);
        end
        // Flush puts the register back at the head
        if (flush && last_valid && last_has_rd) begin
            map[last_rd] = last_old;
            free_q.push_front(last_new);
            old_q[old_q.size()-1] = 0;
        end
        if (retire_strobe) begin
            if (old_q.size() == 0) begin
                flag("retire pulse with no instruction in flight");
            end else begin
                old = old_q.pop_front();
                if (old != 0) begin
                    free_q.push_back(old);
                end
            end
        end
        last_valid  = accept;
        last_has_rd = takes_rd;
        if (accept) begin
            alloc_count++;
            if (takes_rd) begin
                last_rd  = decode.rd_addr;
                last_old = map[decode.rd_addr];
                last_new = phys_addr_t'(free_q.pop_front());
                map[decode.rd_addr] = last_new;
                old_q.push_back(last_old);
            end else begin
                old_q.push_back(0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sampling at the falling edge, inputs and outputs both settled

    always @(negedge clk) begin
        if (rst) begin
            ready       = 1'b0;
            init_cycles = 0;
            alloc_count = 0;
            last_valid  = 1'b0;
            free_q.delete();
            old_q.delete();
        end else begin
            if (!ready && !init_done) begin
                init_cycles++;
                compare("stall during init", 1, stall);
            end else if (!ready) begin
                // Identity map, upper half free in order
                compare("init cycles", `ARCH_REGS, init_cycles);
                for (int n = 0; n < `ARCH_REGS; n++) begin
                    map[n] = phys_addr_t'(n);
                    free_q.push_back(n + `ARCH_REGS);
                end
                ready = 1'b1;
            end
            if (ready) begin
                check_and_update();
            end
        end
    end

endmodule

// File: testbench/rename_tb.sv
// Testbench for the rename unit; applies the stimulus table to the DUT with a checker watching
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int T_INIT   = 1;
    localparam int T_ORDER  = 2;
    localparam int T_RETIRE = 3;
    localparam int T_FLUSH  = 4;
    localparam int T_IDS    = 5;
    localparam int T_X0     = 6;

    // One table row
    typedef struct packed {
        logic [2:0]  test;
        decode_req_t req;
        logic        flush;
        logic        retire;
    } stim_t;

    logic            clk = 1'b0;
    logic            rst;
    decode_req_t     decode;
    rename_resp_t    rename;
    logic            stall;
    logic            flush;
    logic            retire_strobe;
    logic            init_done;
    logic [8*16-1:0] test_name;
    logic [8*16-1:0] test_names [1:6];
    int              chk_errors;
    int              chk_checks;
    stim_t           stim [$];
    int              seed;
    int              watchdog_cycles = 0;
    int              tests_run = 0;
    int              tests_failed = 0;

    always #10 clk = ~clk;

    rename_unit u_dut (
        .clk           (clk),
        .rst           (rst),
        .decode        (decode),
        .rename        (rename),
        .stall         (stall),
        .flush         (flush),
        .retire_strobe (retire_strobe),
        .init_done     (init_done)
    );

    rename_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .decode        (decode),
        .rename        (rename),
        .stall         (stall),
        .flush         (flush),
        .retire_strobe (retire_strobe),
        .init_done     (init_done),
        .test_name     (test_name),
        .errors        (chk_errors),
        .checks        (chk_checks)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Table construction

    task automatic add_entry(input int test, input logic valid, input logic uses_rd,
                             input int rd, input int rs0, input int rs1,
                             input logic fl, input logic ret);
        stim_t e;
        e.test           = test[2:0];
        e.req.valid      = valid;
        e.req.uses_rd    = uses_rd;
        e.req.rd_addr    = arch_addr_t'(rd);
        e.req.rs_addr[0] = arch_addr_t'(rs0);
        e.req.rs_addr[1] = arch_addr_t'(rs1);
        e.flush          = fl;
        e.retire         = ret;
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        test_names[T_INIT]   = "init_map";
        test_names[T_ORDER]  = "rename_order";
        test_names[T_RETIRE] = "retire_order";
        test_names[T_FLUSH]  = "flush_rollback";
        test_names[T_IDS]    = "id_window";
        test_names[T_X0]     = "x0_dest";
        // Identity reads, two registers per row, no decode
        for (int k = 0; k < `ARCH_REGS / 2; k++) begin
            add_entry(T_INIT, 0, 0, 0, 2 * k, 2 * k + 1, 0, 0);
        end
        add_entry(T_ORDER, 1, 1, 1, 0, 0, 0, 0);
        add_entry(T_ORDER, 1, 1, 2, 1, 0, 0, 0);
        add_entry(T_ORDER, 1, 1, 3, 2, 1, 0, 0);
        add_entry(T_ORDER, 1, 1, 5, 1, 2, 0, 0);
        add_entry(T_ORDER, 0, 0, 0, 3, 5, 0, 0);
        repeat (4) add_entry(T_RETIRE, 0, 0, 0, 0, 0, 0, 1);
        // Drains 36..63, then the four registers freed above
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            add_entry(T_RETIRE, 1, 1, (r[4:0] == 0) ? 1 : r[4:0], r[9:5], r[14:10], 0, k > 0);
        end
        add_entry(T_RETIRE, 0, 0, 0, 0, 0, 0, 1);
        add_entry(T_FLUSH, 1, 1, 7, 7, 0, 0, 0);
        add_entry(T_FLUSH, 0, 0, 0, 0, 0, 1, 0);
        add_entry(T_FLUSH, 0, 0, 0, 7, 1, 0, 0);
        add_entry(T_FLUSH, 1, 1, 7, 7, 0, 0, 0);
        add_entry(T_FLUSH, 1, 1, 8, 7, 8, 0, 0);
        // Decode alongside a flush is dropped
        add_entry(T_FLUSH, 1, 1, 9, 8, 0, 1, 0);
        add_entry(T_FLUSH, 0, 0, 0, 8, 9, 0, 0);
        repeat (3) add_entry(T_FLUSH, 0, 0, 0, 0, 0, 0, 1);
        for (int k = 0; k < `MAX_IDS; k++) begin
            add_entry(T_IDS, 1, 1, 10 + k, k, 0, 0, 0);
        end
        // Held on a full id window until its retire lands
        add_entry(T_IDS, 1, 1, 18, 10, 11, 0, 1);
        repeat (`MAX_IDS) add_entry(T_IDS, 0, 0, 0, 0, 0, 0, 1);
        add_entry(T_X0, 1, 1, 0, 4, 6, 0, 0);
        add_entry(T_X0, 1, 0, 6, 4, 6, 0, 0);
        add_entry(T_X0, 1, 1, 4, 0, 4, 0, 0);
        add_entry(T_X0, 0, 0, 0, 4, 6, 0, 0);
        repeat (3) add_entry(T_X0, 0, 0, 0, 0, 0, 0, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driving and reporting

    task automatic apply_entry(input stim_t e);
        decode        = e.req;
        flush         = e.flush;
        retire_strobe = e.retire;
        @(negedge clk);
        // Request held through stall, flush and retire pulse once
        while (e.req.valid && stall && !e.flush) begin
            @(posedge clk);
            #1;
            flush         = 1'b0;
            retire_strobe = 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic close_test(input int t, input int err_base);
        int errs;
        errs = chk_errors - err_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %0s: pass", test_names[t]);
        end else begin
            tests_failed++;
            $display("test %0s: fail with %0d errors", test_names[t], errs);
        end
    endtask

    initial begin
        int err_base;
        rst           = 1'b1;
        decode        = '0;
        flush         = 1'b0;
        retire_strobe = 1'b0;
        seed          = 32'h175e940c;
        err_base      = 0;
        build_table();
        watchdog_cycles = stim.size() * 4 + 100;
        test_name = test_names[stim[0].test];
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        do @(negedge clk); while (!init_done);
        @(posedge clk);
        #1;
        for (int k = 0; k < stim.size(); k++) begin
            if (k > 0 && stim[k].test != stim[k-1].test) begin
                close_test(stim[k-1].test, err_base);
                err_base  = chk_errors;
                test_name = test_names[stim[k].test];
            end
            apply_entry(stim[k]);
        end
        decode        = '0;
        flush         = 1'b0;
        retire_strobe = 1'b0;
        repeat (2) @(negedge clk);
        close_test(stim[stim.size()-1].test, err_base);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, chk_checks, chk_errors);
        if (chk_errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verilog/id_tracker.sv
// In-order instruction id allocator; gives decode the next id and names the oldest at retire
`timescale 1ns/10ps
`include "rename_cfg.svh"

module id_tracker
    import rename_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc,
    input  logic           alloc_uses_rd,
    input  logic           retire_strobe,
    output id_t            next_id,
    output retire_packet_t oldest,
    output logic           ids_full
);

    localparam int ID_W = $clog2(`MAX_IDS);

    id_t alloc_ptr;
    id_t retire_ptr;
    logic [ID_W:0] inflight;
    // Destination flag per id
    logic [`MAX_IDS-1:0] has_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Allocation and retire pointers

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ptr  <= '0;
            retire_ptr <= '0;
            inflight   <= '0;
        end else begin
            if (alloc) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            // Oldest always leaves first
            if (retire_strobe) begin
                retire_ptr <= retire_ptr + 1'b1;
            end
            case ({alloc, retire_strobe})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // Recorded at allocation, read back at retire
    always_ff @(posedge clk) begin
        if (alloc) begin
            has_rd[alloc_ptr] <= alloc_uses_rd;
        end
    end

    assign next_id  = alloc_ptr;
    assign ids_full = (inflight == `MAX_IDS);

    // Retire view of the oldest instruction
    assign oldest.valid   = retire_strobe;
    assign oldest.id      = retire_ptr;
    assign oldest.uses_rd = has_rd[retire_ptr];

    // A retire with nothing outstanding would free a stale register
    retire_when_idle: assert property (@(posedge clk) disable iff (rst)
        retire_strobe |-> (inflight != '0))
        else $error("retire with no instruction in flight");

endmodule

// File: verilog/issue_stage.sv
// Single-entry issue register; holds the instruction renamed last cycle so a flush can undo it
`timescale 1ns/10ps

module issue_stage
    import rename_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          accept,
    input  logic          flush,
    input  decode_req_t   decode,
    input  id_t           id,
    output issue_packet_t issue
);

    logic       stage_valid;
    logic       uses_rd;
    arch_addr_t rd_addr;
    id_t        issue_id;

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy

    // Only valid for the cycle right after an accept
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= accept & ~flush;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload

    // Destination and id of the accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            uses_rd  <= decode.uses_rd;
            rd_addr  <= decode.rd_addr;
            issue_id <= id;
        end
    end

    assign issue.stage_valid = stage_valid;
    assign issue.uses_rd     = uses_rd;
    assign issue.rd_addr     = rd_addr;
    assign issue.id          = issue_id;

endmodule

// File: verilog/register_free_list.sv
// Circular queue of free physical registers; renamer pops on rename, pushes on init and retire
`timescale 1ns/10ps
`include "rename_cfg.svh"

module register_free_list
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  phys_addr_t push_data,
    input  logic       pop,
    input  logic       rollback,
    output phys_addr_t pop_data,
    output logic       empty,
    output logic       full
);

    // One slot per register outside the architectural set
    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    phys_addr_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic [PTR_W:0] count_up;
    logic [PTR_W:0] count_down;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    // Rollback hands back the last popped slot, so it counts as a push
    assign count_up   = {{PTR_W{1'b0}}, push} + {{PTR_W{1'b0}}, rollback};
    assign count_down = {{PTR_W{1'b0}}, pop};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Step back one entry; the popped value is still in the slot
            if (rollback) begin
                rd_ptr <= rd_ptr - 1'b1;
            end else if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_up - count_down;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    // Head of queue, visible the cycle after its push
    assign pop_data = entries[rd_ptr];

    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Stall logic upstream must keep renames away from an empty list
    pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("free list popped while empty");

    // More frees than registers means a double release somewhere
    push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("free list pushed while full");

endmodule

// File: verilog/rename_cfg.svh
// Sizing macros for the rename front end; include wherever a register, id or port count is needed
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Architectural register count, x0 included
`define ARCH_REGS 32

// Physical register count
// Upper half forms the initial free list
`define PHYS_REGS 64

// Instructions that may be in flight between decode and retire
`define MAX_IDS 8

// Source operands translated per instruction
`define READ_PORTS 2

`endif

// File: verilog/rename_pkg.sv
// Types shared by the rename blocks; import wherever an address, id or packet is used
`include "rename_cfg.svh"

package rename_pkg;

    // Register and id numbers
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_addr_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_addr_t;
    typedef logic [$clog2(`MAX_IDS)-1:0]   id_t;

    // Decode request as presented to the rename unit
    typedef struct packed {
        logic                          valid;
        logic                          uses_rd;
        arch_addr_t                    rd_addr;
        arch_addr_t [`READ_PORTS-1:0]  rs_addr;
    } decode_req_t;

    // Same-cycle rename answer back to decode
    typedef struct packed {
        phys_addr_t [`READ_PORTS-1:0]  phys_rs_addr;
        phys_addr_t                    phys_rd_addr;
        id_t                           id;
    } rename_resp_t;

    // Last renamed instruction, kept for a flush
    typedef struct packed {
        logic       stage_valid;
        logic       uses_rd;
        arch_addr_t rd_addr;
        id_t        id;
    } issue_packet_t;

    // Oldest instruction leaving the machine
    // uses_rd only set for a destination other than x0
    typedef struct packed {
        logic valid;
        id_t  id;
        logic uses_rd;
    } retire_packet_t;

endpackage

// File: verilog/rename_unit.sv
// Top of the rename front end; wires map, free list, id tracker and issue stage, makes stall
`timescale 1ns/10ps

module rename_unit
    import rename_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  decode_req_t  decode,
    output rename_resp_t rename,
    output logic         stall,
    input  logic         flush,
    input  logic         retire_strobe,
    output logic         init_done
);

    logic           accept;
    logic           alloc_has_rd;
    logic           free_push;
    logic           free_pop;
    logic           free_rollback;
    logic           free_empty;
    logic           ids_full;
    phys_addr_t     free_push_data;
    phys_addr_t     free_pop_data;
    id_t            next_id;
    retire_packet_t oldest;
    issue_packet_t  issue;

    ////////////////////////////////////////////////////////////////////////////
    // Back-pressure

    // Held through init, empty free list or a full id window
    assign stall = ~init_done | free_empty | ids_full;

    // Flush cycle drops the request
    assign accept = decode.valid & ~stall & ~flush;

    // Destination other than x0
    assign alloc_has_rd = decode.uses_rd & (decode.rd_addr != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Blocks

    renamer u_renamer (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .accept         (accept),
        .id             (next_id),
        .issue          (issue),
        .flush          (flush),
        .retire         (oldest),
        .free_push      (free_push),
        .free_push_data (free_push_data),
        .free_pop       (free_pop),
        .free_rollback  (free_rollback),
        .free_pop_data  (free_pop_data),
        .rename         (rename),
        .init_done      (init_done)
    );

    // Full flag only feeds the list's own check
    register_free_list u_free_list (
        .clk       (clk),
        .rst       (rst),
        .push      (free_push),
        .push_data (free_push_data),
        .pop       (free_pop),
        .rollback  (free_rollback),
        .pop_data  (free_pop_data),
        .empty     (free_empty),
        .full      ()
    );

    id_tracker u_id_tracker (
        .clk           (clk),
        .rst           (rst),
        .alloc         (accept),
        .alloc_uses_rd (alloc_has_rd),
        .retire_strobe (retire_strobe),
        .next_id       (next_id),
        .oldest        (oldest),
        .ids_full      (ids_full)
    );

    issue_stage u_issue_stage (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .flush  (flush),
        .decode (decode),
        .id     (next_id),
        .issue  (issue)
    );

endmodule

// File: verilog/renamer.sv
// Speculative register map with per-id old mappings; drives the free list and answers decode
`timescale 1ns/10ps
`include "rename_cfg.svh"

module renamer
    import rename_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  decode_req_t    decode,
    input  logic           accept,
    input  id_t            id,
    input  issue_packet_t  issue,
    input  logic           flush,
    input  retire_packet_t retire,
    output logic           free_push,
    output phys_addr_t     free_push_data,
    output logic           free_pop,
    output logic           free_rollback,
    input  phys_addr_t     free_pop_data,
    output rename_resp_t   rename,
    output logic           init_done
);

    localparam int AW = $clog2(`ARCH_REGS);

    // No entry for x0 since it reads as physical 0
    phys_addr_t spec_map [1:`ARCH_REGS-1];
    // Mapping each in-flight destination replaced
    phys_addr_t id_to_old [`MAX_IDS];
    // Old mapping of the instruction now in issue
    phys_addr_t rollback_phys;

    logic [AW:0] clear_index;
    logic        init_active;
    logic        rename_valid;
    logic        rollback;
    logic        retire_free;
    logic        map_we;
    arch_addr_t  map_widx;
    phys_addr_t  map_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Post-reset initialization

    // Walks 0..31 once; top bit set marks the end
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_index <= '0;
        end else if (init_active) begin
            clear_index <= clear_index + 1'b1;
        end
    end

    assign init_active = ~clear_index[AW];
    assign init_done   = clear_index[AW];

    ////////////////////////////////////////////////////////////////////////////
    // Control strobes

    // Only real destinations take a register
    assign rename_valid = accept & decode.uses_rd & (decode.rd_addr != '0);

    // Undo the issue-stage rename
    assign rollback = flush & issue.stage_valid & issue.uses_rd & (issue.rd_addr != '0);

    // A flushed instruction has its slot zeroed and frees nothing
    // Same holds when the flush and its retire share a cycle
    assign retire_free = retire.valid & retire.uses_rd & (id_to_old[retire.id] != '0)
                         & ~(rollback & (retire.id == issue.id));

    ////////////////////////////////////////////////////////////////////////////
    // Free list side

    assign free_pop      = rename_valid;
    assign free_rollback = rollback;
    assign free_push     = init_active | retire_free;

    // Init loads 32..63 and later the retired old mappings
    assign free_push_data = init_active ? {1'b1, clear_index[AW-1:0]} : id_to_old[retire.id];

    ////////////////////////////////////////////////////////////////////////////
    // Speculative map

    // Init first, then rollback, then a new rename
    always_comb begin
        if (init_active) begin
            map_widx  = clear_index[AW-1:0];
            map_wdata = {1'b0, clear_index[AW-1:0]};
        end else if (rollback) begin
            map_widx  = issue.rd_addr;
            map_wdata = rollback_phys;
        end else begin
            map_widx  = decode.rd_addr;
            map_wdata = free_pop_data;
        end
    end

    // Entry 0 stays out of the write path
    assign map_we = (init_active | rollback | rename_valid) & (map_widx != '0);

    always_ff @(posedge clk) begin
        if (map_we) begin
            spec_map[map_widx] <= map_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Old mapping bookkeeping

    always_ff @(posedge clk) begin
        if (rename_valid) begin
            rollback_phys   <= spec_map[decode.rd_addr];
            id_to_old[id]   <= spec_map[decode.rd_addr];
        end else if (rollback) begin
            // Register went back to the list head already
            id_to_old[issue.id] <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rename answer

    // Sources see the map before this cycle's write
    always_comb begin
        for (int i = 0; i < `READ_PORTS; i++) begin
            if (decode.rs_addr[i] == '0) begin
                rename.phys_rs_addr[i] = '0;
            end else begin
                rename.phys_rs_addr[i] = spec_map[decode.rs_addr[i]];
            end
        end
        rename.phys_rd_addr = rename_valid ? free_pop_data : '0;
        rename.id           = id;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Physical 0 belongs to x0 alone
    for (genvar i = 0; i < `READ_PORTS; i++) begin : g_src_check
        phys0_reserved: assert property (@(posedge clk) disable iff (rst)
            (init_done && decode.rs_addr[i] != '0) |-> (rename.phys_rs_addr[i] != '0))
            else $error("source other than x0 reads physical register 0");
    end

    // A nonzero destination appears exactly when a rename pops the list
    rd_phys_nonzero: assert property (@(posedge clk) disable iff (rst)
        rename_valid == (rename.phys_rd_addr != '0))
        else $error("physical destination does not match the rename strobe");

endmodule
